// ==== core_consts.svh ====
/*
 * Core-wide constants for the three-stage RV32I pipeline.
 * Include this in every RTL file and in the testbench.
 */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath and program counter
`define CORE_XLEN        32
`define CORE_REG_ADDR_W  5
`define CORE_PC_STEP     4
`define CORE_RESET_PC    0

// --------------------------------------------------
// major opcodes
`define CORE_OP_LUI      7'b0110111
`define CORE_OP_OPIMM    7'b0010011
`define CORE_OP_OP       7'b0110011
`define CORE_OP_BRANCH   7'b1100011
`define CORE_OP_LOAD     7'b0000011
`define CORE_OP_STORE    7'b0100011

// funct7 for SUB and SRA/SRAI
`define CORE_F7_ALT      7'b0100000

// funct3 of the ALU groups
`define CORE_F3_ADD      3'b000
`define CORE_F3_SLL      3'b001
`define CORE_F3_SLT      3'b010
`define CORE_F3_SLTU     3'b011
`define CORE_F3_XOR      3'b100
`define CORE_F3_SR       3'b101
`define CORE_F3_OR       3'b110
`define CORE_F3_AND      3'b111

// only word access is supported on the data bus
`define CORE_F3_WORD     3'b010

`endif

// ==== core_pkg.sv ====
/*
 * Pipeline types of the core: ALU and branch operations, the registered
 * decode record and the writeback record shared by execute, decode and
 * the register file.
 */
`default_nettype none

`include "core_consts.svh"

package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_op_e;

    // --------------------------------------------------
    // decode result, one instruction in the ID slot
    typedef struct packed {
        logic                        valid;
        logic [`CORE_XLEN-1:0]       pc;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic                        rd_en;
        alu_op_e                     alu_op;
        logic                        use_imm;
        logic [`CORE_XLEN-1:0]       imm;
        br_op_e                      br_op;
        logic                        mem_rd;
        logic                        mem_we;
    } id_ctrl_t;

    typedef struct packed {
        logic                        en;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [`CORE_XLEN-1:0]       data;
    } wb_t;

endpackage

`default_nettype wire

// ==== decode_stage.sv ====
/*
 * Decode stage. Turns the fetched word into a registered control record,
 * clearing every enable for a squashed fetch, and presents both source
 * operands with the result of the previous instruction forwarded in.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module decode_stage (
    input  wire                          clk,
    input  wire                          reset,
    input  wire [`CORE_XLEN-1:0]         if_pc_i,
    input  wire                          if_valid_i,
    input  wire [`CORE_XLEN-1:0]         ibus_rdata_i,
    input  wire core_pkg::wb_t           wb_i,
    input  wire [`CORE_XLEN-1:0]         rs1_raw_i,
    input  wire [`CORE_XLEN-1:0]         rs2_raw_i,
    output logic [`CORE_REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [`CORE_REG_ADDR_W-1:0]  rs2_addr_o,
    output core_pkg::id_ctrl_t           id_ctrl_o,
    output logic [`CORE_XLEN-1:0]        rs1_o,
    output logic [`CORE_XLEN-1:0]        rs2_o
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    instr_u   ins;
    id_ctrl_t dec;
    logic     alt;
    logic     fwd1_q;
    logic     fwd2_q;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic sel_alt);
        case (f3)
            `CORE_F3_ADD:  return sel_alt ? ALU_SUB : ALU_ADD;
            `CORE_F3_SLL:  return ALU_SLL;
            `CORE_F3_SLT:  return ALU_SLT;
            `CORE_F3_SLTU: return ALU_SLTU;
            `CORE_F3_XOR:  return ALU_XOR;
            `CORE_F3_SR:   return sel_alt ? ALU_SRA : ALU_SRL;
            `CORE_F3_OR:   return ALU_OR;
            default:       return ALU_AND;
        endcase
    endfunction

    // funct3 of BEQ..BGEU, 010 and 011 are reserved
    function automatic br_op_e br_sel(input logic [2:0] f3);
        case (f3)
            3'b000:  return BR_EQ;
            3'b001:  return BR_NE;
            3'b100:  return BR_LT;
            3'b101:  return BR_GE;
            3'b110:  return BR_LTU;
            3'b111:  return BR_GEU;
            default: return BR_NONE;
        endcase
    endfunction

    assign ins        = ibus_rdata_i;
    assign rs1_addr_o = ins.r.rs1;
    assign rs2_addr_o = ins.r.rs2;

    // SRAI keeps funct7 in the immediate field, ADDI must not see it
    assign alt = (ins.r.funct7 == `CORE_F7_ALT) &&
                 (ins.r.opcode == `CORE_OP_OP || ins.r.funct3 == `CORE_F3_SR);

    // --------------------------------------------------
    // decode
    always_comb begin
        dec        = '0;
        dec.valid  = if_valid_i;
        dec.pc     = if_pc_i;
        dec.rd     = ins.r.rd;
        dec.alu_op = alu_sel(ins.r.funct3, alt);
        dec.imm    = {{20{ins.i.imm[11]}}, ins.i.imm};
        if (if_valid_i) begin
            case (ins.r.opcode)
                `CORE_OP_LUI: begin
                    dec.rd_en   = 1'b1;
                    dec.alu_op  = ALU_PASS_B;
                    dec.use_imm = 1'b1;
                    dec.imm     = {ins.u.imm, 12'b0};
                end
                `CORE_OP_OPIMM: begin
                    dec.rd_en   = 1'b1;
                    dec.use_imm = 1'b1;
                end
                `CORE_OP_OP: dec.rd_en = 1'b1;
                `CORE_OP_BRANCH: begin
                    dec.br_op = br_sel(ins.b.funct3);
                    dec.imm   = {{20{ins.b.imm12}}, ins.b.imm11, ins.b.imm10_5,
                                 ins.b.imm4_1, 1'b0};
                end
                `CORE_OP_LOAD: begin
                    dec.rd_en  = (ins.i.funct3 == `CORE_F3_WORD);
                    dec.mem_rd = (ins.i.funct3 == `CORE_F3_WORD);
                end
                `CORE_OP_STORE: begin
                    dec.mem_we = (ins.s.funct3 == `CORE_F3_WORD);
                    dec.imm    = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
                end
                default: ;
            endcase
            if (dec.rd == '0) begin
                dec.rd_en = 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // ID register and forward flags
    always_ff @(posedge clk) begin
        id_ctrl_o <= dec;
        // instruction now in ID writes back while this one sits in ID
        fwd1_q    <= id_ctrl_o.rd_en && (id_ctrl_o.rd == ins.r.rs1);
        fwd2_q    <= id_ctrl_o.rd_en && (id_ctrl_o.rd == ins.r.rs2);
        if (reset) begin
            id_ctrl_o.valid  <= 1'b0;
            id_ctrl_o.rd_en  <= 1'b0;
            id_ctrl_o.br_op  <= BR_NONE;
            id_ctrl_o.mem_rd <= 1'b0;
            id_ctrl_o.mem_we <= 1'b0;
            fwd1_q           <= 1'b0;
            fwd2_q           <= 1'b0;
        end
    end

    assign rs1_o = fwd1_q ? wb_i.data : rs1_raw_i;
    assign rs2_o = fwd2_q ? wb_i.data : rs2_raw_i;

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
/*
 * Execute and writeback. Resolves branches and drives the data bus straight
 * from the instruction in ID, registers the ALU result, and picks load data
 * or the ALU result for writeback one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module execute_stage #(
    parameter int DBUS_ADDR_WIDTH = 14
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire core_pkg::id_ctrl_t      id_ctrl_i,
    input  wire [`CORE_XLEN-1:0]         rs1_i,
    input  wire [`CORE_XLEN-1:0]         rs2_i,
    input  wire [`CORE_XLEN-1:0]         dbus_rdata_i,
    output logic [`CORE_XLEN-1:0]        next_pc_o,
    output logic                         redirect_o,
    output logic [DBUS_ADDR_WIDTH-1:0]   dbus_addr_o,
    output logic                         dbus_rd_o,
    output logic                         dbus_we_o,
    output logic [`CORE_XLEN-1:0]        dbus_wdata_o,
    output core_pkg::wb_t                wb_o
);
    import core_pkg::*;

    localparam int XLEN = `CORE_XLEN;

    logic [XLEN-1:0]             exp_pc_q;
    logic                        taken;
    logic [XLEN-1:0]             op_b;
    logic [XLEN-1:0]             alu_res;
    logic [XLEN-1:0]             mem_addr;
    logic [XLEN-1:0]             alu_q;
    logic [`CORE_REG_ADDR_W-1:0] rd_q;
    logic                        rd_en_q;
    logic                        load_q;

    // --------------------------------------------------
    // branch
    always_comb begin
        case (id_ctrl_i.br_op)
            BR_EQ:   taken = (rs1_i == rs2_i);
            BR_NE:   taken = (rs1_i != rs2_i);
            BR_LT:   taken = ($signed(rs1_i) < $signed(rs2_i));
            BR_GE:   taken = ($signed(rs1_i) >= $signed(rs2_i));
            BR_LTU:  taken = (rs1_i < rs2_i);
            BR_GEU:  taken = (rs1_i >= rs2_i);
            default: taken = 1'b0;
        endcase
    end

    // hold the expected PC while ID carries a bubble
    always_comb begin
        if (!id_ctrl_i.valid) begin
            next_pc_o = exp_pc_q;
        end else if (taken) begin
            next_pc_o = id_ctrl_i.pc + id_ctrl_i.imm;
        end else begin
            next_pc_o = id_ctrl_i.pc + XLEN'(`CORE_PC_STEP);
        end
    end

    assign redirect_o = taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            exp_pc_q <= XLEN'(`CORE_RESET_PC);
        end else begin
            exp_pc_q <= next_pc_o;
        end
    end

    // --------------------------------------------------
    // alu
    assign op_b = id_ctrl_i.use_imm ? id_ctrl_i.imm : rs2_i;

    always_comb begin
        case (id_ctrl_i.alu_op)
            ALU_ADD:    alu_res = rs1_i + op_b;
            ALU_SUB:    alu_res = rs1_i - op_b;
            ALU_SLL:    alu_res = rs1_i << op_b[4:0];
            ALU_SLT:    alu_res = XLEN'($signed(rs1_i) < $signed(op_b));
            ALU_SLTU:   alu_res = XLEN'(rs1_i < op_b);
            ALU_XOR:    alu_res = rs1_i ^ op_b;
            ALU_SRL:    alu_res = rs1_i >> op_b[4:0];
            ALU_SRA:    alu_res = $unsigned($signed(rs1_i) >>> op_b[4:0]);
            ALU_OR:     alu_res = rs1_i | op_b;
            ALU_AND:    alu_res = rs1_i & op_b;
            default:    alu_res = op_b;
        endcase
    end

    // data bus, word addressed
    assign mem_addr     = rs1_i + id_ctrl_i.imm;
    assign dbus_addr_o  = mem_addr[DBUS_ADDR_WIDTH+1:2];
    assign dbus_rd_o    = id_ctrl_i.mem_rd;
    assign dbus_we_o    = id_ctrl_i.mem_we;
    assign dbus_wdata_o = rs2_i;

    // --------------------------------------------------
    // writeback
    always_ff @(posedge clk) begin
        alu_q <= alu_res;
        rd_q  <= id_ctrl_i.rd;
        if (reset) begin
            rd_en_q <= 1'b0;
            load_q  <= 1'b0;
        end else begin
            rd_en_q <= id_ctrl_i.rd_en;
            load_q  <= id_ctrl_i.mem_rd;
        end
    end

    always_comb begin
        wb_o.en   = rd_en_q;
        wb_o.rd   = rd_q;
        wb_o.data = load_q ? dbus_rdata_i : alu_q;
    end

    // decode never marks one instruction as both load and store
    a_rd_we_excl: assert property (@(posedge clk) disable iff (reset)
        !(dbus_rd_o && dbus_we_o));

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
/*
 * Fetch unit: program counter, instruction bus address and the fetch slot.
 * The fetched word is accepted only when its PC is the one execute expects,
 * which squashes the wrong-path words behind a taken branch.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module fetch_unit #(
    parameter int IBUS_ADDR_WIDTH = 14
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          redirect_i,
    input  wire [IBUS_ADDR_WIDTH+1:0]    next_pc_i,
    output logic [IBUS_ADDR_WIDTH-1:0]   ibus_addr_o,
    output logic [IBUS_ADDR_WIDTH+1:0]   if_pc_o,
    output logic                         if_valid_o
);
    localparam int PC_W = IBUS_ADDR_WIDTH + 2;
    localparam logic [PC_W-1:0] RESET_PC = PC_W'(`CORE_RESET_PC);

    logic [PC_W-1:0] pc_q;
    logic [PC_W-1:0] if_pc_q;
    logic            if_valid_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= next_pc_i;
        end else begin
            pc_q <= pc_q + PC_W'(`CORE_PC_STEP);
        end
    end

    // memory answers one cycle later, so the PC follows the word
    always_ff @(posedge clk) begin
        if_pc_q    <= pc_q;
        if_valid_q <= !reset;
    end

    assign ibus_addr_o = pc_q[PC_W-1:2];
    assign if_pc_o     = if_pc_q;
    assign if_valid_o  = if_valid_q && (if_pc_q == next_pc_i);

    // branch targets from execute must keep the PC on word boundaries
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        redirect_i |=> pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== register_file.sv ====
/*
 * 31 x 32 register file, x0 reads as zero.
 * Both read ports are synchronous. A write to the index being read in the
 * same cycle is passed straight to the read data.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module register_file (
    input  wire                          clk,
    input  wire                          reset,
    input  wire core_pkg::wb_t           wb_i,
    input  wire [`CORE_REG_ADDR_W-1:0]   rs1_addr_i,
    input  wire [`CORE_REG_ADDR_W-1:0]   rs2_addr_i,
    output logic [`CORE_XLEN-1:0]        rs1_data_o,
    output logic [`CORE_XLEN-1:0]        rs2_data_o
);
    logic [`CORE_XLEN-1:0] regs [1:31];

    function automatic logic [`CORE_XLEN-1:0] read_port(
        input logic [`CORE_REG_ADDR_W-1:0] addr
    );
        if (addr == '0) return '0;
        // write-through
        if (wb_i.en && wb_i.rd == addr) return wb_i.data;
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (wb_i.en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
        rs1_data_o <= read_port(rs1_addr_i);
        rs2_data_o <= read_port(rs2_addr_i);
    end

    // decode must drop rd_en for x0 destinations
    a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
        wb_i.en |-> wb_i.rd != '0);

endmodule

`default_nettype wire

// ==== riscv_core.sv ====
/*
 * Three-stage RV32I core: fetch, decode, execute/writeback.
 * Instruction and data memories answer one cycle after the address.
 * The core never stalls.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module riscv_core #(
    parameter int IBUS_ADDR_WIDTH = 14,
    parameter int DBUS_ADDR_WIDTH = 14
) (
    input  wire                          clk,
    input  wire                          reset,
    output logic [IBUS_ADDR_WIDTH-1:0]   ibus_addr_o,
    input  wire [`CORE_XLEN-1:0]         ibus_rdata_i,
    output logic [DBUS_ADDR_WIDTH-1:0]   dbus_addr_o,
    output logic                         dbus_rd_o,
    output logic                         dbus_we_o,
    output logic [`CORE_XLEN-1:0]        dbus_wdata_o,
    input  wire [`CORE_XLEN-1:0]         dbus_rdata_i
);
    import core_pkg::*;

    localparam int XLEN = `CORE_XLEN;
    localparam int PC_W = IBUS_ADDR_WIDTH + 2;

    logic [XLEN-1:0]             next_pc;
    logic                        redirect;
    logic [PC_W-1:0]             if_pc;
    logic                        if_valid;
    logic [`CORE_REG_ADDR_W-1:0] rs1_addr;
    logic [`CORE_REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]             rs1_raw;
    logic [XLEN-1:0]             rs2_raw;
    logic [XLEN-1:0]             rs1;
    logic [XLEN-1:0]             rs2;
    id_ctrl_t                    id_ctrl;
    wb_t                         wb;

    fetch_unit #(.IBUS_ADDR_WIDTH(IBUS_ADDR_WIDTH)) i_fetch_unit (
        .clk, .reset,
        .redirect_i  (redirect),
        .next_pc_i   (next_pc[PC_W-1:0]),
        .ibus_addr_o (ibus_addr_o),
        .if_pc_o     (if_pc),
        .if_valid_o  (if_valid)
    );

    decode_stage i_decode_stage (
        .clk, .reset,
        .if_pc_i      (XLEN'(if_pc)),
        .if_valid_i   (if_valid),
        .ibus_rdata_i (ibus_rdata_i),
        .wb_i         (wb),
        .rs1_raw_i    (rs1_raw),
        .rs2_raw_i    (rs2_raw),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .id_ctrl_o    (id_ctrl),
        .rs1_o        (rs1),
        .rs2_o        (rs2)
    );

    register_file i_register_file (
        .clk, .reset,
        .wb_i       (wb),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_raw),
        .rs2_data_o (rs2_raw)
    );

    execute_stage #(.DBUS_ADDR_WIDTH(DBUS_ADDR_WIDTH)) i_execute_stage (
        .clk, .reset,
        .id_ctrl_i    (id_ctrl),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .dbus_rdata_i (dbus_rdata_i),
        .next_pc_o    (next_pc),
        .redirect_o   (redirect),
        .dbus_addr_o  (dbus_addr_o),
        .dbus_rd_o    (dbus_rd_o),
        .dbus_we_o    (dbus_we_o),
        .dbus_wdata_o (dbus_wdata_o),
        .wb_o         (wb)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f src.f --top-module tb_riscv_core -o tb_riscv_core
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_riscv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== rv_isa_pkg.sv ====
/*
 * RV32I instruction formats.
 * Each struct lists the fields from bit 31 down to bit 0. The union gives
 * all views of one fetched word, so decode picks the format it needs.
 */
`default_nettype none

`include "core_consts.svh"

package rv_isa_pkg;

    typedef struct packed {
        logic [6:0]                  funct7;
        logic [`CORE_REG_ADDR_W-1:0] rs2;
        logic [`CORE_REG_ADDR_W-1:0] rs1;
        logic [2:0]                  funct3;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [6:0]                  opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]                 imm;
        logic [`CORE_REG_ADDR_W-1:0] rs1;
        logic [2:0]                  funct3;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [6:0]                  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]                  imm_hi;
        logic [`CORE_REG_ADDR_W-1:0] rs2;
        logic [`CORE_REG_ADDR_W-1:0] rs1;
        logic [2:0]                  funct3;
        logic [4:0]                  imm_lo;
        logic [6:0]                  opcode;
    } s_fmt_t;

    // branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic                        imm12;
        logic [5:0]                  imm10_5;
        logic [`CORE_REG_ADDR_W-1:0] rs2;
        logic [`CORE_REG_ADDR_W-1:0] rs1;
        logic [2:0]                  funct3;
        logic [3:0]                  imm4_1;
        logic                        imm11;
        logic [6:0]                  opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]                 imm;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [6:0]                  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
    } instr_u;

endpackage

`default_nettype wire

// ==== src.f ====
+incdir+.
rv_isa_pkg.sv
core_pkg.sv
register_file.sv
fetch_unit.sv
decode_stage.sv
execute_stage.sv
riscv_core.sv
tb_riscv_core.sv

// ==== tb_riscv_core.sv ====
/*
 * Testbench for the three-stage RV32I core.
 * Builds small programs, runs each after a reset against an instruction ROM
 * and a data RAM, and checks every store on the data bus against a
 * reference instruction-set model of the same program.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module tb_riscv_core;
    localparam logic [31:0] SELF_LOOP = 32'h0000_0063;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [13:0] ibus_addr;
    logic [31:0] ibus_rdata = '0;
    logic [13:0] dbus_addr;
    logic        dbus_rd;
    logic        dbus_we;
    logic [31:0] dbus_wdata;
    logic [31:0] dbus_rdata = '0;

    logic [31:0] rom [0:255];
    logic [31:0] ram [0:255];
    logic [31:0] prog [$];
    logic [13:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          st_idx = 0;
    int          n_loads = 0;
    int          ld_cnt = 0;
    int          mismatches = 0;
    int          other_errs = 0;
    logic        reset_prev = 1'b0;
    logic [31:0] lfsr_state = 32'hb6ea_9092;
    int          st_addr;

    // BEQ BNE BLT BGE BLTU BGEU
    logic [2:0]  f3_list [0:5] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

    riscv_core i_riscv_core (
        .clk, .reset,
        .ibus_addr_o  (ibus_addr),
        .ibus_rdata_i (ibus_rdata),
        .dbus_addr_o  (dbus_addr),
        .dbus_rd_o    (dbus_rd),
        .dbus_we_o    (dbus_we),
        .dbus_wdata_o (dbus_wdata),
        .dbus_rdata_i (dbus_rdata)
    );

    always #2 clk = ~clk;

    // both memories answer one cycle after the address
    // data RAM returns a word only for a read strobe, refilled during reset
    always @(posedge clk) begin
        ibus_rdata <= rom[ibus_addr[7:0]];
        dbus_rdata <= dbus_rd ? ram[dbus_addr[7:0]] : '0;
        if (reset) begin
            for (int k = 0; k < 256; k++) ram[k] <= ram_fill(8'(k));
        end else if (dbus_we) begin
            ram[dbus_addr[7:0]] <= dbus_wdata;
        end
    end

    // --------------------------------------------------
    // helpers
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int k = 0; k < n; k++) begin
            b = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], b};
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [31:0] ram_fill(input logic [7:0] a);
        return {a, ~a, a ^ 8'h5a, a + 8'hc3};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `CORE_OP_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
                                          input logic [2:0] f3, input int rd,
                                          input logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_sw(input int rs2, input int off);
        logic [11:0] imm;
        imm = 12'(off);
        return {imm[11:5], 5'(rs2), 5'd0, `CORE_F3_WORD, imm[4:0], `CORE_OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, rs2,
                                          input logic [12:0] off);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11],
                `CORE_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_lui(input int rd, input logic [19:0] imm);
        return {imm, 5'(rd), `CORE_OP_LUI};
    endfunction

    // store a register to the next free word
    function automatic void store_next(input int rs);
        prog.push_back(enc_sw(rs, st_addr));
        st_addr += 4;
    endfunction

    function automatic void load_random(input int rd);
        prog.push_back(enc_lui(rd, 20'(rand_bits(20))));
        prog.push_back(enc_i(12'(rand_bits(12)), rd, `CORE_F3_ADD, rd, `CORE_OP_OPIMM));
    endfunction

    // shifts keep only shamt and the SRA bit in the immediate
    function automatic logic [11:0] imm_for(input logic [2:0] f3);
        if (f3 == `CORE_F3_SLL) return {7'd0, 5'(rand_bits(5))};
        if (f3 == `CORE_F3_SR) return {rand_bits(1) ? `CORE_F7_ALT : 7'd0, 5'(rand_bits(5))};
        return 12'(rand_bits(12));
    endfunction

    // --------------------------------------------------
    // reference model of the kept RV32I subset
    function automatic void ref_model();
        logic [31:0] x [0:31];
        logic [31:0] mem [0:255];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] imm;
        logic [2:0]  f3;
        logic        alt;
        logic        tk;
        exp_addr.delete();
        exp_data.delete();
        n_loads = 0;
        for (int k = 0; k < 32; k++) x[k] = '0;
        for (int k = 0; k < 256; k++) mem[k] = ram_fill(8'(k));
        pc = '0;
        for (int step = 0; step < 2000; step++) begin
            w = (pc[31:2] < prog.size()) ? prog[pc[31:2]] : '0;
            if (w == SELF_LOOP) break;
            a = x[w[19:15]];
            b = x[w[24:20]];
            f3 = w[14:12];
            imm = {{20{w[31]}}, w[31:20]};
            res = '0;
            pc = pc + 4;
            case (w[6:0])
                `CORE_OP_LUI: x[w[11:7]] = {w[31:12], 12'b0};
                `CORE_OP_OP, `CORE_OP_OPIMM: begin
                    alt = (w[31:25] == `CORE_F7_ALT);
                    if (w[6:0] == `CORE_OP_OPIMM) begin
                        b = imm;
                        if (f3 != `CORE_F3_SR) alt = 1'b0;
                    end
                    case (f3)
                        `CORE_F3_ADD:  res = alt ? a - b : a + b;
                        `CORE_F3_SLL:  res = a << b[4:0];
                        `CORE_F3_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                        `CORE_F3_SLTU: res = {31'd0, a < b};
                        `CORE_F3_XOR:  res = a ^ b;
                        `CORE_F3_SR: begin
                            if (alt) begin
                                res = $signed(a) >>> b[4:0];
                            end else begin
                                res = a >> b[4:0];
                            end
                        end
                        `CORE_F3_OR:   res = a | b;
                        default:       res = a & b;
                    endcase
                    x[w[11:7]] = res;
                end
                `CORE_OP_LOAD: begin
                    x[w[11:7]] = mem[8'((a + imm) >> 2)];
                    n_loads++;
                end
                `CORE_OP_STORE: begin
                    imm = {{20{w[31]}}, w[31:25], w[11:7]};
                    mem[8'((a + imm) >> 2)] = b;
                    exp_addr.push_back(14'((a + imm) >> 2));
                    exp_data.push_back(b);
                end
                `CORE_OP_BRANCH: begin
                    case (f3)
                        3'b000:  tk = (a == b);
                        3'b001:  tk = (a != b);
                        3'b100:  tk = ($signed(a) < $signed(b));
                        3'b101:  tk = ($signed(a) >= $signed(b));
                        3'b110:  tk = (a < b);
                        default: tk = (a >= b);
                    endcase
                    if (tk) pc = pc - 4 + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
                default: ;
            endcase
            x[0] = '0;
        end
    endfunction

    // --------------------------------------------------
    // compare every store with the expected list
    always @(posedge clk) begin
        reset_prev <= reset;
        assert (!(reset && reset_prev && (dbus_we || dbus_rd))) else begin
            other_errs++;
            $display("data bus strobe active during reset at %0t", $time);
        end
        if (!reset && dbus_rd) begin
            ld_cnt++;
        end
        if (!reset && dbus_we) begin
            assert (st_idx < exp_addr.size()) else begin
                other_errs++;
                $display("extra store at %0t to word %h", $time, dbus_addr);
            end
            if (st_idx < exp_addr.size()) begin
                assert (dbus_addr == exp_addr[st_idx]) else begin
                    mismatches++;
                    $display("mismatch at %0t: dbus_addr_o expected %h got %h",
                             $time, exp_addr[st_idx], dbus_addr);
                end
                assert (dbus_wdata == exp_data[st_idx]) else begin
                    mismatches++;
                    $display("mismatch at %0t: dbus_wdata_o expected %h got %h",
                             $time, exp_data[st_idx], dbus_wdata);
                end
                st_idx++;
            end
        end
    end

    task automatic run_program();
        int cyc;
        int limit;
        prog.push_back(SELF_LOOP);
        ref_model();
        limit = 4 * prog.size() + 100;
        @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        for (int k = 0; k < 256; k++) begin
            rom[k] = (k < prog.size()) ? prog[k] : '0;
        end
        st_idx = 0;
        ld_cnt = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        cyc = 0;
        while (st_idx < exp_addr.size()) begin
            @(posedge clk);
            cyc++;
            if (cyc > limit) begin
                $display("timeout after %0d cycles, %0d of %0d stores missing",
                         cyc, exp_addr.size() - st_idx, exp_addr.size());
                $display("errors: %0d mismatches, %0d other", mismatches, other_errs + 1);
                $display("STATUS: FAIL");
                $finish;
            end
        end
        // extra stores would show up here
        repeat (20) @(posedge clk);
        assert (ld_cnt == n_loads) else begin
            other_errs++;
            $display("expected %0d loads on the data bus, saw %0d", n_loads, ld_cnt);
        end
        prog.delete();
    endtask

    initial begin
        logic [2:0] f3;
        // ALU groups
        st_addr = 0;
        load_random(1);
        load_random(2);
        for (int k = 0; k < 8; k++) begin
            prog.push_back(enc_r(7'd0, 2, 1, 3'(k), 3));
            store_next(3);
        end
        prog.push_back(enc_r(`CORE_F7_ALT, 2, 1, `CORE_F3_ADD, 3));
        store_next(3);
        prog.push_back(enc_r(`CORE_F7_ALT, 2, 1, `CORE_F3_SR, 3));
        store_next(3);
        for (int k = 0; k < 8; k++) begin
            prog.push_back(enc_i(imm_for(3'(k)), 1, 3'(k), 4, `CORE_OP_OPIMM));
            store_next(4);
        end
        prog.push_back(enc_i({`CORE_F7_ALT, 5'd7}, 1, `CORE_F3_SR, 4, `CORE_OP_OPIMM));
        store_next(4);
        run_program();

        // random back-to-back sequences
        st_addr = 0;
        for (int r = 1; r < 8; r++) load_random(r);
        for (int k = 0; k < 40; k++) begin
            f3 = 3'(rand_bits(3));
            if (rand_bits(1))
                prog.push_back(enc_r((f3 == `CORE_F3_ADD || f3 == `CORE_F3_SR) &&
                               rand_bits(1) ? `CORE_F7_ALT : 7'd0,
                               rand_bits(3), rand_bits(3), f3, 1 + rand_bits(3) % 7));
            else
                prog.push_back(enc_i(imm_for(f3), rand_bits(3), f3, 1 + rand_bits(3) % 7,
                               `CORE_OP_OPIMM));
        end
        for (int r = 1; r < 8; r++) store_next(r);
        run_program();

        // load-use
        st_addr = 512;
        prog.push_back(enc_i(12'd8, 0, `CORE_F3_WORD, 5, `CORE_OP_LOAD));
        prog.push_back(enc_i(12'd1, 5, `CORE_F3_ADD, 6, `CORE_OP_OPIMM));
        store_next(6);
        prog.push_back(enc_i(12'd12, 0, `CORE_F3_WORD, 7, `CORE_OP_LOAD));
        prog.push_back(enc_r(7'd0, 7, 7, `CORE_F3_ADD, 8));
        store_next(8);
        prog.push_back(enc_i(12'd40, 0, `CORE_F3_WORD, 9, `CORE_OP_LOAD));
        store_next(9);
        run_program();

        // branches, stores right behind each one
        st_addr = 0;
        prog.push_back(enc_i(12'hffb, 0, `CORE_F3_ADD, 1, `CORE_OP_OPIMM));
        prog.push_back(enc_i(12'd3, 0, `CORE_F3_ADD, 2, `CORE_OP_OPIMM));
        foreach (f3_list[k]) begin
            for (int p = 0; p < 3; p++) begin
                prog.push_back(enc_b(f3_list[k], p == 1 ? 2 : 1, p == 0 ? 2 : 1, 13'd12));
                store_next(2);
                store_next(1);
                store_next(2);
            end
        end
        run_program();

        // x0 stays zero
        st_addr = 64;
        load_random(1);
        prog.push_back(enc_i(12'd123, 0, `CORE_F3_ADD, 0, `CORE_OP_OPIMM));
        store_next(0);
        prog.push_back(enc_lui(0, 20'habcde));
        store_next(0);
        prog.push_back(enc_r(7'd0, 1, 1, `CORE_F3_ADD, 0));
        store_next(0);
        store_next(1);
        run_program();

        $display("errors: %0d mismatches, %0d other", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
